// ==== source/bridge_pkg.sv ====
// Bridge package with shared widths, types, credit counts and AXI response codes
package bridge_pkg;

   // Field widths of the single-beat host and AXI transfers
   localparam int unsigned ADDR_W = 32;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned STRB_W = DATA_W / 8;
   localparam int unsigned ID_W   = 4;
   localparam int unsigned RESP_W = 2;
   localparam int unsigned CNT_W  = 3;

   // Packed FIFO entries of the two request paths
   localparam int unsigned WR_ENTRY_W = ID_W + ADDR_W + STRB_W + DATA_W;
   localparam int unsigned RD_ENTRY_W = ID_W + ADDR_W;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;
   typedef logic [ID_W-1:0]   id_t;
   typedef logic [RESP_W-1:0] resp_t;
   typedef logic [CNT_W-1:0]  cnt_t;

   // AXI response encodings
   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   // Request credits held by the host after reset, also the path FIFO depth
   localparam int unsigned OUTSTANDING = 4;

   // Response credits held by the bridge after reset
   localparam int unsigned RSP_CREDITS = 2;

   // Output register of the response merger
   typedef enum logic {
      IDLE,
      HOLD
   } merge_state_t;

endpackage

// ==== source/sync_fifo.sv ====
// Synchronous register-array FIFO that presents its head entry combinationally
`timescale 1ns/1ns

module sync_fifo #(
   parameter int unsigned DEPTH = 4,
   parameter int unsigned WIDTH = 8
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic             push_i,
   input  logic [WIDTH-1:0] push_data_i,
   input  logic             pop_i,
   output logic [WIDTH-1:0] pop_data_o,
   output logic             empty_o,
   output logic             full_o
);

   logic [WIDTH-1:0]             mem_q [DEPTH];
   logic [$clog2(DEPTH)-1:0]     wr_ptr_q;
   logic [$clog2(DEPTH)-1:0]     rd_ptr_q;
   logic [$clog2(DEPTH+1)-1:0]   count_q;

   assign pop_data_o = mem_q[rd_ptr_q];
   assign empty_o    = (count_q == '0);
   assign full_o     = (count_q == DEPTH);

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem_q[wr_ptr_q] <= push_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
         end
         // Simultaneous push and pop leave the fill level unchanged
         if (push_i && !pop_i) begin
            count_q <= count_q + 1'b1;
         end else if (pop_i && !push_i) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   a_no_overflow_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(push_i && full_o) && !(pop_i && empty_o));

endmodule

// ==== source/axi_write_path.sv ====
// Write request path that queues host writes and drives AXI AW and W
`timescale 1ns/1ns

module axi_write_path (
   input  logic              clk_i,
   input  logic              rst_n_i,

   // Host request port
   input  logic              req_valid_i,
   input  logic              req_write_i,
   input  bridge_pkg::addr_t req_addr_i,
   input  bridge_pkg::data_t req_wdata_i,
   input  bridge_pkg::strb_t req_strb_i,
   input  bridge_pkg::id_t   req_id_i,

   // AXI AW channel
   output bridge_pkg::id_t   aw_id_o,
   output bridge_pkg::addr_t aw_addr_o,
   output logic              aw_valid_o,
   input  logic              aw_ready_i,

   // AXI W channel
   output bridge_pkg::data_t w_data_o,
   output bridge_pkg::strb_t w_strb_o,
   output logic              w_last_o,
   output logic              w_valid_o,
   input  logic              w_ready_i
);

   logic [bridge_pkg::WR_ENTRY_W-1:0] push_data;
   logic [bridge_pkg::WR_ENTRY_W-1:0] head_data;
   logic                              push;
   logic                              pop;
   logic                              empty;
   logic                              aw_done_q;
   logic                              w_done_q;
   logic                              aw_hs;
   logic                              w_hs;

   assign push      = req_valid_i && req_write_i;
   assign push_data = {req_id_i, req_addr_i, req_strb_i, req_wdata_i};

   sync_fifo #(
      .DEPTH (bridge_pkg::OUTSTANDING),
      .WIDTH (bridge_pkg::WR_ENTRY_W)
   ) u_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (push),
      .push_data_i (push_data),
      .pop_i       (pop),
      .pop_data_o  (head_data),
      .empty_o     (empty),
      .full_o      ()
   );

   // Head entry drives both channels until it is popped
   assign {aw_id_o, aw_addr_o, w_strb_o, w_data_o} = head_data;

   // Single-beat writes only
   assign w_last_o = 1'b1;

   assign aw_valid_o = !empty && !aw_done_q;
   assign w_valid_o  = !empty && !w_done_q;

   assign aw_hs = aw_valid_o && aw_ready_i;
   assign w_hs  = w_valid_o && w_ready_i;

   // Entry retires once both channels have completed, in either order
   assign pop = !empty && (aw_done_q || aw_hs) && (w_done_q || w_hs);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         aw_done_q <= 1'b0;
         w_done_q  <= 1'b0;
      end else if (pop) begin
         aw_done_q <= 1'b0;
         w_done_q  <= 1'b0;
      end else begin
         if (aw_hs) begin
            aw_done_q <= 1'b1;
         end
         if (w_hs) begin
            w_done_q <= 1'b1;
         end
      end
   end

   a_aw_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      aw_valid_o && !aw_ready_i |=>
         aw_valid_o && $stable(aw_addr_o) && $stable(aw_id_o));

endmodule

// ==== source/axi_read_path.sv ====
// Read request path that queues host reads and drives AXI AR
`timescale 1ns/1ns

module axi_read_path (
   input  logic              clk_i,
   input  logic              rst_n_i,

   // Host request port
   input  logic              req_valid_i,
   input  logic              req_write_i,
   input  bridge_pkg::addr_t req_addr_i,
   input  bridge_pkg::id_t   req_id_i,

   // AXI AR channel
   output bridge_pkg::id_t   ar_id_o,
   output bridge_pkg::addr_t ar_addr_o,
   output logic              ar_valid_o,
   input  logic              ar_ready_i
);

   logic [bridge_pkg::RD_ENTRY_W-1:0] push_data;
   logic [bridge_pkg::RD_ENTRY_W-1:0] head_data;
   logic                              push;
   logic                              pop;
   logic                              empty;

   assign push      = req_valid_i && !req_write_i;
   assign push_data = {req_id_i, req_addr_i};

   sync_fifo #(
      .DEPTH (bridge_pkg::OUTSTANDING),
      .WIDTH (bridge_pkg::RD_ENTRY_W)
   ) u_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (push),
      .push_data_i (push_data),
      .pop_i       (pop),
      .pop_data_o  (head_data),
      .empty_o     (empty),
      .full_o      ()
   );

   // FIFO head sits on AR while any read is queued
   assign {ar_id_o, ar_addr_o} = head_data;
   assign ar_valid_o           = !empty;

   // Next entry shows up in the cycle after the handshake
   assign pop = ar_valid_o && ar_ready_i;

   a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ar_valid_o && !ar_ready_i |=>
         ar_valid_o && $stable(ar_addr_o) && $stable(ar_id_o));

endmodule

// ==== source/resp_merge.sv ====
// Response merger that arbitrates AXI B and R into one credit-controlled host stream
`timescale 1ns/1ns

module resp_merge (
   input  logic              clk_i,
   input  logic              rst_n_i,

   // AXI B channel
   input  bridge_pkg::id_t   b_id_i,
   input  bridge_pkg::resp_t b_resp_i,
   input  logic              b_valid_i,
   output logic              b_ready_o,

   // AXI R channel
   input  bridge_pkg::id_t   r_id_i,
   input  bridge_pkg::data_t r_data_i,
   input  bridge_pkg::resp_t r_resp_i,
   input  logic              r_last_i,
   input  logic              r_valid_i,
   output logic              r_ready_o,

   // Host response port
   output logic              rsp_valid_o,
   output logic              rsp_write_o,
   output bridge_pkg::id_t   rsp_id_o,
   output bridge_pkg::data_t rsp_rdata_o,
   output logic              rsp_err_o,
   input  logic              rsp_credit_i,

   // Request credit return
   output logic              req_credit_o
);

   bridge_pkg::merge_state_t state_q;
   bridge_pkg::cnt_t         credits_q;
   bridge_pkg::id_t          id_q;
   bridge_pkg::data_t        rdata_q;
   logic                     write_q;
   logic                     err_q;
   logic                     prio_r_q;
   logic                     can_accept;
   logic                     b_hs;
   logic                     r_hs;

   // Free output register and at least one response credit
   assign can_accept = (state_q == bridge_pkg::IDLE) && (credits_q != '0);

   // Round-robin holds off the losing channel while both are valid
   assign b_ready_o = can_accept && !(r_valid_i && prio_r_q);
   assign r_ready_o = can_accept && !(b_valid_i && !prio_r_q);

   assign b_hs = b_valid_i && b_ready_o;
   assign r_hs = r_valid_i && r_ready_o;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q   <= bridge_pkg::IDLE;
         credits_q <= bridge_pkg::cnt_t'(bridge_pkg::RSP_CREDITS);
         prio_r_q  <= 1'b0;
      end else begin
         case (state_q)
            bridge_pkg::IDLE: begin
               if (b_hs || r_hs) begin
                  state_q <= bridge_pkg::HOLD;
               end
            end
            default: begin
               state_q <= bridge_pkg::IDLE;
            end
         endcase
         // Taken on the handshake, returned by the host pulse
         credits_q <= credits_q - bridge_pkg::cnt_t'(b_hs || r_hs)
                                + bridge_pkg::cnt_t'(rsp_credit_i);
         if (b_hs) begin
            prio_r_q <= 1'b1;
         end else if (r_hs) begin
            prio_r_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (b_hs) begin
         write_q <= 1'b1;
         id_q    <= b_id_i;
         rdata_q <= '0;
         err_q   <= (b_resp_i != bridge_pkg::RESP_OKAY);
      end else if (r_hs) begin
         write_q <= 1'b0;
         id_q    <= r_id_i;
         rdata_q <= r_data_i;
         err_q   <= (r_resp_i != bridge_pkg::RESP_OKAY);
      end
   end

   // One cycle of HOLD per response
   assign rsp_valid_o  = (state_q == bridge_pkg::HOLD);
   assign req_credit_o = (state_q == bridge_pkg::HOLD);
   assign rsp_write_o  = write_q;
   assign rsp_id_o     = id_q;
   assign rsp_rdata_o  = rdata_q;
   assign rsp_err_o    = err_q;

   a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credits_q <= bridge_pkg::cnt_t'(bridge_pkg::RSP_CREDITS));

   a_r_last: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_hs |-> r_last_i);

endmodule

// ==== source/axi_host_bridge.sv ====
// Host-to-AXI bridge top with loose host request, response and AXI ports
`timescale 1ns/1ns

module axi_host_bridge (
   input  logic              clk_i,
   input  logic              rst_n_i,

   // Host request port
   input  logic              req_valid_i,
   input  logic              req_write_i,
   input  bridge_pkg::addr_t req_addr_i,
   input  bridge_pkg::data_t req_wdata_i,
   input  bridge_pkg::strb_t req_strb_i,
   input  bridge_pkg::id_t   req_id_i,
   output logic              req_credit_o,

   // Host response port
   output logic              rsp_valid_o,
   output logic              rsp_write_o,
   output bridge_pkg::id_t   rsp_id_o,
   output bridge_pkg::data_t rsp_rdata_o,
   output logic              rsp_err_o,
   input  logic              rsp_credit_i,

   // AXI AW channel
   output bridge_pkg::id_t   aw_id_o,
   output bridge_pkg::addr_t aw_addr_o,
   output logic              aw_valid_o,
   input  logic              aw_ready_i,

   // AXI W channel
   output bridge_pkg::data_t w_data_o,
   output bridge_pkg::strb_t w_strb_o,
   output logic              w_last_o,
   output logic              w_valid_o,
   input  logic              w_ready_i,

   // AXI B channel
   input  bridge_pkg::id_t   b_id_i,
   input  bridge_pkg::resp_t b_resp_i,
   input  logic              b_valid_i,
   output logic              b_ready_o,

   // AXI AR channel
   output bridge_pkg::id_t   ar_id_o,
   output bridge_pkg::addr_t ar_addr_o,
   output logic              ar_valid_o,
   input  logic              ar_ready_i,

   // AXI R channel
   input  bridge_pkg::id_t   r_id_i,
   input  bridge_pkg::data_t r_data_i,
   input  bridge_pkg::resp_t r_resp_i,
   input  logic              r_last_i,
   input  logic              r_valid_i,
   output logic              r_ready_o
);

   axi_write_path u_write_path (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_valid_i (req_valid_i),
      .req_write_i (req_write_i),
      .req_addr_i  (req_addr_i),
      .req_wdata_i (req_wdata_i),
      .req_strb_i  (req_strb_i),
      .req_id_i    (req_id_i),
      .aw_id_o     (aw_id_o),
      .aw_addr_o   (aw_addr_o),
      .aw_valid_o  (aw_valid_o),
      .aw_ready_i  (aw_ready_i),
      .w_data_o    (w_data_o),
      .w_strb_o    (w_strb_o),
      .w_last_o    (w_last_o),
      .w_valid_o   (w_valid_o),
      .w_ready_i   (w_ready_i)
   );

   axi_read_path u_read_path (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_valid_i (req_valid_i),
      .req_write_i (req_write_i),
      .req_addr_i  (req_addr_i),
      .req_id_i    (req_id_i),
      .ar_id_o     (ar_id_o),
      .ar_addr_o   (ar_addr_o),
      .ar_valid_o  (ar_valid_o),
      .ar_ready_i  (ar_ready_i)
   );

   // B and R belong to the merger alone
   resp_merge u_resp_merge (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .b_id_i       (b_id_i),
      .b_resp_i     (b_resp_i),
      .b_valid_i    (b_valid_i),
      .b_ready_o    (b_ready_o),
      .r_id_i       (r_id_i),
      .r_data_i     (r_data_i),
      .r_resp_i     (r_resp_i),
      .r_last_i     (r_last_i),
      .r_valid_i    (r_valid_i),
      .r_ready_o    (r_ready_o),
      .rsp_valid_o  (rsp_valid_o),
      .rsp_write_o  (rsp_write_o),
      .rsp_id_o     (rsp_id_o),
      .rsp_rdata_o  (rsp_rdata_o),
      .rsp_err_o    (rsp_err_o),
      .rsp_credit_i (rsp_credit_i),
      .req_credit_o (req_credit_o)
   );

endmodule

// ==== bench/axi_slave_model.sv ====
// Behavioral AXI slave with random ready latency and an address-derived data and response model
`timescale 1ns/1ns

module axi_slave_model (
   input  logic              clk_i,
   input  logic              rst_n_i,

   // AXI AW and W channels
   input  bridge_pkg::id_t   aw_id_i,
   input  bridge_pkg::addr_t aw_addr_i,
   input  logic              aw_valid_i,
   output logic              aw_ready_o,
   input  bridge_pkg::data_t w_data_i,
   input  bridge_pkg::strb_t w_strb_i,
   input  logic              w_last_i,
   input  logic              w_valid_i,
   output logic              w_ready_o,

   // AXI B channel
   output bridge_pkg::id_t   b_id_o,
   output bridge_pkg::resp_t b_resp_o,
   output logic              b_valid_o,
   input  logic              b_ready_i,

   // AXI AR and R channels
   input  bridge_pkg::id_t   ar_id_i,
   input  bridge_pkg::addr_t ar_addr_i,
   input  logic              ar_valid_i,
   output logic              ar_ready_o,
   output bridge_pkg::id_t   r_id_o,
   output bridge_pkg::data_t r_data_o,
   output bridge_pkg::resp_t r_resp_o,
   output logic              r_last_o,
   output logic              r_valid_o,
   input  logic              r_ready_i
);

   integer            seed = 32'hec6e;
   int                w_count = 0;
   bridge_pkg::addr_t aw_addr_q[$];
   bridge_pkg::id_t   aw_id_q[$];
   bridge_pkg::addr_t ar_addr_q[$];
   bridge_pkg::id_t   ar_id_q[$];

   // Last accepted write, looked at by the testbench
   bridge_pkg::addr_t seen_addr;
   bridge_pkg::data_t seen_data;
   bridge_pkg::strb_t seen_strb;
   logic              seen_last;

   function automatic bridge_pkg::resp_t resp_for(input bridge_pkg::addr_t addr);
      return addr[31] ? bridge_pkg::RESP_SLVERR : bridge_pkg::RESP_OKAY;
   endfunction

   function automatic int rand_delay();
      return $unsigned($random(seed)) % 4;
   endfunction

   // AW acceptance after a random wait
   initial begin
      aw_ready_o = 1'b0;
      forever begin
         @(negedge clk_i);
         if (rst_n_i && aw_valid_i) begin
            repeat (rand_delay()) @(posedge clk_i);
            @(posedge clk_i);
            #1;
            aw_ready_o = 1'b1;
            @(negedge clk_i);
            aw_addr_q.push_back(aw_addr_i);
            aw_id_q.push_back(aw_id_i);
            seen_addr = aw_addr_i;
            @(posedge clk_i);
            #1;
            aw_ready_o = 1'b0;
         end
      end
   end

   // W acceptance, independent of AW
   initial begin
      w_ready_o = 1'b0;
      forever begin
         @(negedge clk_i);
         if (rst_n_i && w_valid_i) begin
            repeat (rand_delay()) @(posedge clk_i);
            @(posedge clk_i);
            #1;
            w_ready_o = 1'b1;
            @(negedge clk_i);
            seen_data = w_data_i;
            seen_strb = w_strb_i;
            seen_last = w_last_i;
            w_count++;
            @(posedge clk_i);
            #1;
            w_ready_o = 1'b0;
         end
      end
   end

   // B once both halves of a write have arrived
   initial begin
      b_valid_o = 1'b0;
      b_id_o    = '0;
      b_resp_o  = bridge_pkg::RESP_OKAY;
      forever begin
         @(posedge clk_i);
         #1;
         if (aw_id_q.size() > 0 && w_count > 0) begin
            b_id_o   = aw_id_q.pop_front();
            b_resp_o = resp_for(aw_addr_q.pop_front());
            w_count--;
            b_valid_o = 1'b1;
            @(negedge clk_i);
            while (!b_ready_i) @(negedge clk_i);
            @(posedge clk_i);
            #1;
            b_valid_o = 1'b0;
         end
      end
   end

   // AR acceptance after a random wait
   initial begin
      ar_ready_o = 1'b0;
      forever begin
         @(negedge clk_i);
         if (rst_n_i && ar_valid_i) begin
            repeat (rand_delay()) @(posedge clk_i);
            @(posedge clk_i);
            #1;
            ar_ready_o = 1'b1;
            @(negedge clk_i);
            ar_addr_q.push_back(ar_addr_i);
            ar_id_q.push_back(ar_id_i);
            @(posedge clk_i);
            #1;
            ar_ready_o = 1'b0;
         end
      end
   end

   // R data is the address scrambled with a fixed pattern
   initial begin
      r_valid_o = 1'b0;
      r_last_o  = 1'b1;
      r_id_o    = '0;
      r_data_o  = '0;
      r_resp_o  = bridge_pkg::RESP_OKAY;
      forever begin
         @(posedge clk_i);
         #1;
         if (ar_addr_q.size() > 0) begin
            r_id_o    = ar_id_q.pop_front();
            r_data_o  = ar_addr_q[0] ^ 32'hA5A5_5A5A;
            r_resp_o  = resp_for(ar_addr_q.pop_front());
            r_valid_o = 1'b1;
            @(negedge clk_i);
            while (!r_ready_i) @(negedge clk_i);
            @(posedge clk_i);
            #1;
            r_valid_o = 1'b0;
         end
      end
   end

endmodule

// ==== bench/tb_axi_host_bridge.sv ====
// Testbench for the host-to-AXI bridge with directed tests, credit tracking and a watchdog
`timescale 1ns/1ns

module tb_axi_host_bridge;

   localparam int NUM_TESTS       = 5;
   localparam int CYCLES_PER_TEST = 2000;
   localparam int CLK_PERIOD      = 10;
   localparam int DRAIN_LIMIT     = 1000;

   logic              clk;
   logic              rst_n;
   logic              req_valid;
   logic              req_write;
   bridge_pkg::addr_t req_addr;
   bridge_pkg::data_t req_wdata;
   bridge_pkg::strb_t req_strb;
   bridge_pkg::id_t   req_id;
   logic              req_credit;
   logic              rsp_valid;
   logic              rsp_write;
   bridge_pkg::id_t   rsp_id;
   bridge_pkg::data_t rsp_rdata;
   logic              rsp_err;
   logic              rsp_credit;

   bridge_pkg::id_t   aw_id;
   bridge_pkg::addr_t aw_addr;
   logic              aw_valid;
   logic              aw_ready;
   bridge_pkg::data_t w_data;
   bridge_pkg::strb_t w_strb;
   logic              w_last;
   logic              w_valid;
   logic              w_ready;
   bridge_pkg::id_t   b_id;
   bridge_pkg::resp_t b_resp;
   logic              b_valid;
   logic              b_ready;
   bridge_pkg::id_t   ar_id;
   bridge_pkg::addr_t ar_addr;
   logic              ar_valid;
   logic              ar_ready;
   bridge_pkg::id_t   r_id;
   bridge_pkg::data_t r_data;
   bridge_pkg::resp_t r_resp;
   logic              r_last;
   logic              r_valid;
   logic              r_ready;

   integer seed;
   int     errors;
   int     checks;
   int     host_credits;
   int     credits_to_return;
   int     rsp_count;
   int     credit_pulses;
   bit     auto_credit;

   // Expected responses per kind, in issue order
   bridge_pkg::id_t   exp_wr_id_q[$];
   logic              exp_wr_err_q[$];
   bridge_pkg::id_t   exp_rd_id_q[$];
   bridge_pkg::data_t exp_rd_data_q[$];
   logic              exp_rd_err_q[$];

   axi_host_bridge uut (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .req_valid_i  (req_valid),
      .req_write_i  (req_write),
      .req_addr_i   (req_addr),
      .req_wdata_i  (req_wdata),
      .req_strb_i   (req_strb),
      .req_id_i     (req_id),
      .req_credit_o (req_credit),
      .rsp_valid_o  (rsp_valid),
      .rsp_write_o  (rsp_write),
      .rsp_id_o     (rsp_id),
      .rsp_rdata_o  (rsp_rdata),
      .rsp_err_o    (rsp_err),
      .rsp_credit_i (rsp_credit),
      .aw_id_o      (aw_id),
      .aw_addr_o    (aw_addr),
      .aw_valid_o   (aw_valid),
      .aw_ready_i   (aw_ready),
      .w_data_o     (w_data),
      .w_strb_o     (w_strb),
      .w_last_o     (w_last),
      .w_valid_o    (w_valid),
      .w_ready_i    (w_ready),
      .b_id_i       (b_id),
      .b_resp_i     (b_resp),
      .b_valid_i    (b_valid),
      .b_ready_o    (b_ready),
      .ar_id_o      (ar_id),
      .ar_addr_o    (ar_addr),
      .ar_valid_o   (ar_valid),
      .ar_ready_i   (ar_ready),
      .r_id_i       (r_id),
      .r_data_i     (r_data),
      .r_resp_i     (r_resp),
      .r_last_i     (r_last),
      .r_valid_i    (r_valid),
      .r_ready_o    (r_ready)
   );

   axi_slave_model u_slave (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .aw_id_i    (aw_id),
      .aw_addr_i  (aw_addr),
      .aw_valid_i (aw_valid),
      .aw_ready_o (aw_ready),
      .w_data_i   (w_data),
      .w_strb_i   (w_strb),
      .w_last_i   (w_last),
      .w_valid_i  (w_valid),
      .w_ready_o  (w_ready),
      .b_id_o     (b_id),
      .b_resp_o   (b_resp),
      .b_valid_o  (b_valid),
      .b_ready_i  (b_ready),
      .ar_id_i    (ar_id),
      .ar_addr_i  (ar_addr),
      .ar_valid_i (ar_valid),
      .ar_ready_o (ar_ready),
      .r_id_o     (r_id),
      .r_data_o   (r_data),
      .r_resp_o   (r_resp),
      .r_last_o   (r_last),
      .r_valid_o  (r_valid),
      .r_ready_i  (r_ready)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_data(input string name, input bridge_pkg::data_t got,
                             input bridge_pkg::data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input bridge_pkg::addr_t got,
                             input bridge_pkg::addr_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_strb(input string name, input bridge_pkg::strb_t got,
                             input bridge_pkg::strb_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t ns: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_id(input string name, input bridge_pkg::id_t got,
                           input bridge_pkg::id_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t ns: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_write_rsp();
      if (exp_wr_id_q.size() == 0) begin
         errors++;
         $display("Write response at %0t ns with no write outstanding", $time);
      end else begin
         check_id("rsp_id_o", rsp_id, exp_wr_id_q.pop_front());
         check_data("rsp_rdata_o", rsp_rdata, '0);
         check_flag("rsp_err_o", rsp_err, exp_wr_err_q.pop_front());
      end
   endtask

   task automatic check_read_rsp();
      if (exp_rd_id_q.size() == 0) begin
         errors++;
         $display("Read response at %0t ns with no read outstanding", $time);
      end else begin
         check_id("rsp_id_o", rsp_id, exp_rd_id_q.pop_front());
         check_data("rsp_rdata_o", rsp_rdata, exp_rd_data_q.pop_front());
         check_flag("rsp_err_o", rsp_err, exp_rd_err_q.pop_front());
      end
   endtask

   // Host side monitor, sampled mid-cycle
   always @(negedge clk) begin
      if (rst_n) begin
         if (rsp_valid) begin
            rsp_count++;
            check_flag("req_credit_o", req_credit, 1'b1);
            if (auto_credit) begin
               credits_to_return++;
            end
            if (rsp_write === 1'b1) begin
               check_write_rsp();
            end else begin
               check_read_rsp();
            end
         end
         if (req_credit) begin
            credit_pulses++;
            host_credits++;
            if (host_credits > bridge_pkg::OUTSTANDING) begin
               errors++;
               $display("More request credits returned than requests issued at %0t ns", $time);
            end
         end
      end
   end

   // One response credit pulse per cycle while any are owed
   always @(posedge clk) begin
      #1;
      if (credits_to_return > 0) begin
         rsp_credit = 1'b1;
         credits_to_return--;
      end else begin
         rsp_credit = 1'b0;
      end
   end

   task automatic send_req(input logic write, input bridge_pkg::addr_t addr,
                           input bridge_pkg::data_t data, input bridge_pkg::strb_t strb,
                           input bridge_pkg::id_t id);
      @(posedge clk);
      #1;
      while (host_credits == 0) begin
         @(posedge clk);
         #1;
      end
      req_valid = 1'b1;
      req_write = write;
      req_addr  = addr;
      req_wdata = data;
      req_strb  = strb;
      req_id    = id;
      host_credits--;
      if (write) begin
         exp_wr_id_q.push_back(id);
         exp_wr_err_q.push_back(addr[31]);
      end else begin
         exp_rd_id_q.push_back(id);
         exp_rd_data_q.push_back(addr ^ 32'hA5A5_5A5A);
         exp_rd_err_q.push_back(addr[31]);
      end
      @(posedge clk);
      #1;
      req_valid = 1'b0;
   endtask

   task automatic wait_drained();
      int cycles;
      cycles = 0;
      while ((exp_wr_id_q.size() != 0 || exp_rd_id_q.size() != 0) && cycles < DRAIN_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (exp_wr_id_q.size() != 0 || exp_rd_id_q.size() != 0) begin
         errors++;
         $display("Timed out at %0t ns waiting for outstanding responses", $time);
      end
      // Let the last response credit reach the bridge
      repeat (3) @(posedge clk);
   endtask

   task automatic check_reset_state();
      check_flag("aw_valid_o", aw_valid, 1'b0);
      check_flag("w_valid_o", w_valid, 1'b0);
      check_flag("ar_valid_o", ar_valid, 1'b0);
      check_flag("rsp_valid_o", rsp_valid, 1'b0);
      check_flag("req_credit_o", req_credit, 1'b0);
      check_flag("b_ready_o", b_ready, 1'b1);
      check_flag("r_ready_o", r_ready, 1'b1);
   endtask

   task automatic test_single_write();
      int base_rsp;
      base_rsp = rsp_count;
      send_req(1'b1, 32'h0000_1230, 32'hcafe_f00d, 4'b1011, 4'h3);
      wait_drained();
      check_count("responses to a single write", rsp_count - base_rsp, 1);
      check_addr("slave AW address", u_slave.seen_addr, 32'h0000_1230);
      check_data("slave W data", u_slave.seen_data, 32'hcafe_f00d);
      check_strb("slave W strobes", u_slave.seen_strb, 4'b1011);
      check_flag("slave W last", u_slave.seen_last, 1'b1);
   endtask

   task automatic test_single_read();
      int base_rsp;
      base_rsp = rsp_count;
      send_req(1'b0, 32'h0000_2468, '0, '0, 4'h5);
      wait_drained();
      check_count("responses to a single read", rsp_count - base_rsp, 1);
   endtask

   task automatic test_error_resp();
      int base_rsp;
      base_rsp = rsp_count;
      send_req(1'b1, 32'h8000_0010, 32'h0bad_0bad, 4'hf, 4'h6);
      send_req(1'b0, 32'h8000_0020, '0, '0, 4'h7);
      wait_drained();
      check_count("responses to error accesses", rsp_count - base_rsp, 2);
   endtask

   task automatic test_credits();
      int base_rsp;
      int base_pulses;
      int cycles;
      base_rsp    = rsp_count;
      base_pulses = credit_pulses;
      auto_credit = 1'b0;
      send_req(1'b1, 32'h0000_3000, 32'h1111_2222, 4'hf, 4'h8);
      send_req(1'b0, 32'h0000_3100, '0, '0, 4'h9);
      send_req(1'b1, 32'h0000_3200, 32'h3333_4444, 4'h3, 4'ha);
      send_req(1'b0, 32'h0000_3300, '0, '0, 4'hb);
      cycles = 0;
      while (rsp_count - base_rsp < 2 && cycles < DRAIN_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      // Bridge has no response credit left, so nothing more may appear
      repeat (50) @(posedge clk);
      check_count("responses without response credit", rsp_count - base_rsp, 2);
      credits_to_return = credits_to_return + 2;
      auto_credit = 1'b1;
      wait_drained();
      check_count("responses in credit test", rsp_count - base_rsp, 4);
      check_count("req_credit_o pulses in credit test", credit_pulses - base_pulses, 4);
   endtask

   task automatic test_random_mix();
      int                base_rsp;
      int                base_pulses;
      logic              write;
      bridge_pkg::addr_t addr;
      bridge_pkg::data_t data;
      bridge_pkg::strb_t strb;
      bridge_pkg::id_t   id;
      base_rsp    = rsp_count;
      base_pulses = credit_pulses;
      for (int i = 0; i < 40; i++) begin
         write     = $random(seed);
         addr      = $random(seed);
         addr[1:0] = 2'b00;
         data      = $random(seed);
         strb      = $random(seed);
         id        = $random(seed);
         send_req(write, addr, data, strb, id);
      end
      wait_drained();
      check_count("responses in random mix", rsp_count - base_rsp, 40);
      check_count("req_credit_o pulses in random mix", credit_pulses - base_pulses, 40);
   endtask

   initial begin
      seed              = 32'hec6e;
      errors            = 0;
      checks            = 0;
      host_credits      = bridge_pkg::OUTSTANDING;
      credits_to_return = 0;
      rsp_count         = 0;
      credit_pulses     = 0;
      auto_credit       = 1'b1;
      rst_n             = 1'b0;
      req_valid         = 1'b0;
      req_write         = 1'b0;
      req_addr          = '0;
      req_wdata         = '0;
      req_strb          = '0;
      req_id            = '0;
      rsp_credit        = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_reset_state();
      test_single_write();
      test_single_read();
      test_error_resp();
      test_credits();
      test_random_mix();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // Watchdog sized from the number of tests
   initial begin
      #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles before the tests finished",
               NUM_TESTS * CYCLES_PER_TEST);
      $display("Something failed");
      $finish;
   end

endmodule

// ==== list.f ====
source/bridge_pkg.sv
source/sync_fifo.sv
source/axi_write_path.sv
source/axi_read_path.sv
source/resp_merge.sv
source/axi_host_bridge.sv
bench/axi_slave_model.sv
bench/tb_axi_host_bridge.sv

// ==== Bender.yml ====
package:
  name: axi_host_bridge

sources:
  - source/bridge_pkg.sv
  - source/sync_fifo.sv
  - source/axi_write_path.sv
  - source/axi_read_path.sv
  - source/resp_merge.sv
  - source/axi_host_bridge.sv
  - target: test
    files:
      - bench/axi_slave_model.sv
      - bench/tb_axi_host_bridge.sv
